/* filelist.f */
+incdir+rtl
rtl/ooo_pkg.sv
rtl/rename_regfile.sv
rtl/reorder_buffer.sv
rtl/reservation_station.sv
rtl/exec_alu.sv
rtl/ooo_core_top.sv
tb/clk_rst_gen.sv
tb/ooo_core_tb.sv

/* tb/ooo_core_tb.sv */
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module ooo_core_tb;
  import ooo_pkg::*;

  localparam int num_instr   = 24;
  localparam int stall_at    = 14;  // Dispatch index that starts the commit stall
  localparam int stall_len   = 12;
  localparam int cycle_limit = 40 * num_instr + 100;

  logic                      in_clk;
  logic                      in_rst_n;
  logic                      dispatch_valid;
  logic                      dispatch_ready;
  dispatch_t                 dispatch;
  logic                      commit_valid;
  logic                      commit_ready;
  commit_t                   commit;

  dispatch_t                 prog [num_instr];
  commit_t                   expect_q [$];
  logic [`OOO_XLEN-1:0]      model_regs [`OOO_NUM_REGS];
  logic [`OOO_ROB_IDX_W-1:0] next_tag;
  logic [31:0]               rng;
  int                        idx;
  int                        dispatch_count;
  int                        commit_count;
  int                        err_count;
  int                        cycle_count;
  int                        phase;  // 0 ready high, 1 stalled, 2 random
  int                        stall_cycles;

  clk_rst_gen u_clk_rst (
    .in_clk   (in_clk),
    .in_rst_n (in_rst_n)
  );

  ooo_core_top DUT (
    .in_clk         (in_clk),
    .in_rst_n       (in_rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .dispatch       (dispatch),
    .commit_valid   (commit_valid),
    .commit_ready   (commit_ready),
    .commit         (commit)
  );

  function automatic dispatch_t make_instr(alu_op_e op, logic [`OOO_REG_IDX_W-1:0] dst,
                                           logic [`OOO_REG_IDX_W-1:0] src1,
                                           logic [`OOO_REG_IDX_W-1:0] src2,
                                           logic use_imm, logic [`OOO_XLEN-1:0] imm);
    dispatch_t d;
    d.op      = op;
    d.dst     = dst;
    d.src1    = src1;
    d.src2    = src2;
    d.use_imm = use_imm;
    d.imm     = imm;
    return d;
  endfunction

  function automatic logic [`OOO_XLEN-1:0] model_result(alu_op_e op, logic [`OOO_XLEN-1:0] a,
                                                        logic [`OOO_XLEN-1:0] b);
    case (op)
      ALU_ADD: return a + b;
      ALU_SUB: return a - b;
      ALU_AND: return a & b;
      ALU_OR:  return a | b;
      ALU_XOR: return a ^ b;
      ALU_SHL: return a << b[4:0];
      default: return '0;
    endcase
  endfunction

  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  task automatic load_program();
    prog[0]  = make_instr(ALU_ADD, 1, 0, 0, 1'b1, 32'd5);         // First independent ADDI
    prog[1]  = make_instr(ALU_ADD, 2, 1, 0, 1'b1, 32'd3);         // Back-to-back on r1
    prog[2]  = make_instr(ALU_ADD, 3, 1, 2, 1'b0, 32'd0);
    prog[3]  = make_instr(ALU_SUB, 4, 3, 1, 1'b0, 32'd0);
    prog[4]  = make_instr(ALU_SHL, 5, 4, 0, 1'b1, 32'd2);
    prog[5]  = make_instr(ALU_ADD, 0, 1, 0, 1'b1, 32'd100);       // r0 destination
    prog[6]  = make_instr(ALU_ADD, 6, 0, 2, 1'b0, 32'd0);         // r0 still zero
    prog[7]  = make_instr(ALU_XOR, 7, 6, 3, 1'b0, 32'd0);         // Start of long chain
    prog[8]  = make_instr(ALU_OR,  7, 7, 5, 1'b0, 32'd0);
    prog[9]  = make_instr(ALU_AND, 8, 7, 0, 1'b1, 32'h0000_00ff);
    prog[10] = make_instr(ALU_SUB, 8, 8, 7, 1'b0, 32'd0);
    prog[11] = make_instr(ALU_ADD, 9, 0, 0, 1'b1, 32'h0000_1234); // Overtakes the chain
    prog[12] = make_instr(ALU_XOR, 10, 0, 0, 1'b1, 32'hdead_beef);
    prog[13] = make_instr(ALU_OR,  11, 9, 10, 1'b0, 32'd0);
    prog[14] = make_instr(ALU_ADD, 12, 0, 0, 1'b1, 32'd7);
    prog[15] = make_instr(ALU_ADD, 13, 0, 0, 1'b1, 32'd9);
    prog[16] = make_instr(ALU_SHL, 14, 9, 0, 1'b1, 32'd4);
    prog[17] = make_instr(ALU_ADD, 15, 12, 13, 1'b0, 32'd0);
    prog[18] = make_instr(ALU_SUB, 1, 15, 14, 1'b0, 32'd0);       // Wraps below zero
    prog[19] = make_instr(ALU_AND, 2, 10, 11, 1'b0, 32'd0);
    prog[20] = make_instr(ALU_OR,  3, 1, 2, 1'b0, 32'd0);
    prog[21] = make_instr(ALU_XOR, 4, 3, 12, 1'b0, 32'd0);
    prog[22] = make_instr(ALU_ADD, 5, 0, 0, 1'b1, 32'hffff_ffff);
    prog[23] = make_instr(ALU_ADD, 6, 5, 5, 1'b0, 32'd0);         // Carry out dropped
  endtask

  // In-order model of one accepted instruction
  task automatic record_dispatch(input dispatch_t d);
    commit_t              exp;
    logic [`OOO_XLEN-1:0] a;
    logic [`OOO_XLEN-1:0] b;
    a = (d.src1 == '0) ? '0 : model_regs[d.src1];
    b = d.use_imm ? d.imm : ((d.src2 == '0) ? '0 : model_regs[d.src2]);
    exp.dst   = d.dst;
    exp.tag   = next_tag;
    exp.value = model_result(d.op, a, b);
    if (d.dst != '0) begin
      model_regs[d.dst] = exp.value;
    end
    expect_q.push_back(exp);
    next_tag = next_tag + 1'b1;  // Modulo ROB depth
    dispatch_count++;
  endtask

  task automatic check_commit();
    commit_t exp;
    commit_count++;
    assert (expect_q.size() > 0) else begin
      $display("Commit at %0t with no instruction outstanding", $time);
      err_count++;
    end
    if (expect_q.size() > 0) begin
      exp = expect_q.pop_front();
      assert (commit.dst == exp.dst) else begin
        $display("ERR %0t commit.dst got %0d exp %0d", $time, commit.dst, exp.dst);
        err_count++;
      end
      assert (commit.tag == exp.tag) else begin
        $display("ERR %0t commit.tag got %0d exp %0d", $time, commit.tag, exp.tag);
        err_count++;
      end
      assert (commit.value == exp.value) else begin
        $display("ERR %0t commit.value got %h exp %h", $time, commit.value, exp.value);
        err_count++;
      end
    end
  endtask

  task automatic update_commit_ready();
    case (phase)
      0: begin
        if (idx == stall_at) begin
          phase = 1;
          commit_ready <= 1'b0;
        end else begin
          commit_ready <= 1'b1;
        end
      end
      1: begin
        stall_cycles++;  // Edges seen with commit_ready low
        if (stall_cycles == stall_len) begin
          assert (!dispatch_ready && (dispatch_count - commit_count == `OOO_ROB_DEPTH)) else begin
            $display("Commit stall did not fill the ROB at %0t: %0d in flight, ready %0b",
                     $time, dispatch_count - commit_count, dispatch_ready);
            err_count++;
          end
          phase = 2;
          commit_ready <= 1'b1;  // Release the stall
        end else begin
          commit_ready <= 1'b0;
        end
      end
      default: begin
        rng = xorshift32(rng);
        commit_ready <= (rng[1:0] != 2'b00);  // Low about a quarter of the time
      end
    endcase
  endtask

  initial begin
    dispatch_valid = 1'b0;
    dispatch       = '0;
    commit_ready   = 1'b0;
    rng            = 32'd20295;
    next_tag       = '0;
    idx            = 0;
    dispatch_count = 0;
    commit_count   = 0;
    err_count      = 0;
    cycle_count    = 0;
    phase          = 0;
    stall_cycles   = 0;
    for (int r = 0; r < `OOO_NUM_REGS; r++) begin
      model_regs[r] = '0;
    end
    load_program();

    @(posedge in_rst_n);
    @(posedge in_clk);
    assert (!commit_valid) else begin
      $display("ERR %0t commit_valid got %0b exp 0", $time, commit_valid);
      err_count++;
    end
    assert (dispatch_ready) else begin
      $display("ERR %0t dispatch_ready got %0b exp 1", $time, dispatch_ready);
      err_count++;
    end
    dispatch_valid <= 1'b1;
    dispatch       <= prog[0];
    commit_ready   <= 1'b1;

    while ((commit_count < num_instr) && (cycle_count < cycle_limit)) begin
      @(posedge in_clk);
      cycle_count++;
      if (dispatch_count - commit_count >= `OOO_ROB_DEPTH) begin
        assert (!dispatch_ready) else begin
          $display("ERR %0t dispatch_ready got %0b exp 0", $time, dispatch_ready);
          err_count++;
        end
      end
      if (commit_valid && commit_ready) begin
        check_commit();
      end
      if (dispatch_valid && dispatch_ready) begin
        record_dispatch(prog[idx]);
        idx++;
      end
      update_commit_ready();
      dispatch_valid <= (idx < num_instr);
      if (idx < num_instr) begin
        dispatch <= prog[idx];  // Held until accepted
      end
    end

    if (commit_count < num_instr) begin
      $display("Timeout after %0d cycles with %0d of %0d instructions committed",
               cycle_count, commit_count, num_instr);
    end
    $display("Errors: %0d, missing commits: %0d", err_count, num_instr - commit_count);
    if ((err_count == 0) && (commit_count == num_instr)) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* tb/clk_rst_gen.sv */
`timescale 1ns/1ns

module clk_rst_gen (
  output logic in_clk,
  output logic in_rst_n
);

  localparam int half_period  = 4;  // 8 ns clock
  localparam int reset_cycles = 2;

  initial begin
    in_clk = 1'b0;
    forever #half_period in_clk = ~in_clk;
  end

  initial begin
    in_rst_n = 1'b0;
    repeat (reset_cycles) @(posedge in_clk);
    @(negedge in_clk);
    in_rst_n = 1'b1;  // Released between rising edges
  end

endmodule

/* rtl/ooo_core_top.sv */
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module ooo_core_top (
  input  logic               in_clk,
  input  logic               in_rst_n,
  input  logic               dispatch_valid,
  output logic               dispatch_ready,
  input  ooo_pkg::dispatch_t dispatch,
  output logic               commit_valid,
  input  logic               commit_ready,
  output ooo_pkg::commit_t   commit
);
  import ooo_pkg::*;

  logic                      dispatch_fire;
  logic                      commit_fire;
  logic [`OOO_ROB_IDX_W-1:0] alloc_tag;
  logic                      rob_free;
  logic                      rs_free;
  operand_t                  src1_raw;
  operand_t                  src2_raw;
  operand_t                  src1;
  operand_t                  src2;
  cdb_t                      cdb;
  logic                      issue_valid;
  issue_t                    issue;

  // Needs a slot in both windows
  assign dispatch_ready = rob_free && rs_free;
  assign dispatch_fire  = dispatch_valid && dispatch_ready;
  assign commit_fire    = commit_valid && commit_ready;

  rename_regfile u_regfile (
    .in_clk        (in_clk),
    .in_rst_n      (in_rst_n),
    .dispatch      (dispatch),
    .dispatch_fire (dispatch_fire),
    .alloc_tag     (alloc_tag),
    .src1_raw      (src1_raw),
    .src2_raw      (src2_raw),
    .commit_fire   (commit_fire),
    .commit        (commit)
  );

  reorder_buffer u_rob (
    .in_clk        (in_clk),
    .in_rst_n      (in_rst_n),
    .dispatch_fire (dispatch_fire),
    .dispatch      (dispatch),
    .src1_raw      (src1_raw),
    .src2_raw      (src2_raw),
    .src1          (src1),
    .src2          (src2),
    .alloc_tag     (alloc_tag),
    .rob_free      (rob_free),
    .cdb           (cdb),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .commit_ready  (commit_ready)
  );

  reservation_station u_rs (
    .in_clk        (in_clk),
    .in_rst_n      (in_rst_n),
    .dispatch_fire (dispatch_fire),
    .op            (dispatch.op),
    .src1          (src1),
    .src2          (src2),
    .alloc_tag     (alloc_tag),
    .rs_free       (rs_free),
    .cdb           (cdb),
    .issue_valid   (issue_valid),
    .issue         (issue)
  );

  exec_alu u_alu (
    .in_clk      (in_clk),
    .in_rst_n    (in_rst_n),
    .issue_valid (issue_valid),
    .issue       (issue),
    .cdb         (cdb)
  );

endmodule

/* rtl/exec_alu.sv */
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module exec_alu (
  input  logic            in_clk,
  input  logic            in_rst_n,
  input  logic            issue_valid,
  input  ooo_pkg::issue_t issue,
  output ooo_pkg::cdb_t   cdb
);
  import ooo_pkg::*;

  logic [`OOO_XLEN-1:0]      result;
  logic                      cdb_valid;
  logic [`OOO_ROB_IDX_W-1:0] cdb_tag;
  logic [`OOO_XLEN-1:0]      cdb_value;

  always_comb begin
    case (issue.op)
      ALU_ADD: result = issue.a + issue.b;  // Wraps at XLEN
      ALU_SUB: result = issue.a - issue.b;
      ALU_AND: result = issue.a & issue.b;
      ALU_OR:  result = issue.a | issue.b;
      ALU_XOR: result = issue.a ^ issue.b;
      ALU_SHL: result = issue.a << issue.b[4:0];
      default: result = '0;
    endcase
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      cdb_valid <= 1'b0;
    end else begin
      cdb_valid <= issue_valid;  // One-cycle pulse per issue
    end
  end

  always_ff @(posedge in_clk) begin
    if (issue_valid) begin
      cdb_tag   <= issue.tag;
      cdb_value <= result;
    end
  end

  assign cdb = '{valid: cdb_valid, tag: cdb_tag, value: cdb_value};

endmodule

/* rtl/reservation_station.sv */
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module reservation_station (
  input  logic                      in_clk,
  input  logic                      in_rst_n,
  input  logic                      dispatch_fire,
  input  ooo_pkg::alu_op_e          op,
  input  ooo_pkg::operand_t         src1,
  input  ooo_pkg::operand_t         src2,
  input  logic [`OOO_ROB_IDX_W-1:0] alloc_tag,
  output logic                      rs_free,
  input  ooo_pkg::cdb_t             cdb,
  output logic                      issue_valid,
  output ooo_pkg::issue_t           issue
);
  import ooo_pkg::*;

  localparam int rs_idx_w = $clog2(`OOO_RS_DEPTH);

  logic [`OOO_RS_DEPTH-1:0]  ent_valid;
  alu_op_e                   ent_op [`OOO_RS_DEPTH];
  operand_t                  ent_a [`OOO_RS_DEPTH];
  operand_t                  ent_b [`OOO_RS_DEPTH];
  logic [`OOO_ROB_IDX_W-1:0] ent_tag [`OOO_RS_DEPTH];
  logic [rs_idx_w-1:0]       ent_age [`OOO_RS_DEPTH];  // Count of younger entries
  logic [rs_idx_w-1:0]       age_next [`OOO_RS_DEPTH];
  logic [`OOO_RS_DEPTH-1:0]  ent_ready;
  logic [rs_idx_w-1:0]       free_idx;
  logic [rs_idx_w-1:0]       sel_idx;

  // Lowest free slot
  always_comb begin
    rs_free  = 1'b0;
    free_idx = '0;
    for (int i = `OOO_RS_DEPTH - 1; i >= 0; i--) begin
      if (!ent_valid[i]) begin
        rs_free  = 1'b1;
        free_idx = rs_idx_w'(i);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
      ent_ready[i] = ent_valid[i] && ent_a[i].ready && ent_b[i].ready;
    end
  end

  // Oldest ready entry wins
  always_comb begin
    issue_valid = 1'b0;
    sel_idx     = '0;
    for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
      if (ent_ready[i] && (!issue_valid || (ent_age[i] > ent_age[sel_idx]))) begin
        issue_valid = 1'b1;
        sel_idx     = rs_idx_w'(i);
      end
    end
  end

  assign issue = '{op: ent_op[sel_idx], a: ent_a[sel_idx].value,
                   b: ent_b[sel_idx].value, tag: ent_tag[sel_idx]};

  // A new entry ages everyone and an issued one makes older entries one step younger
  always_comb begin
    for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
      age_next[i] = ent_age[i];
      if (dispatch_fire) begin
        age_next[i] = age_next[i] + 1'b1;
      end
      if (issue_valid && (ent_age[i] > ent_age[sel_idx])) begin
        age_next[i] = age_next[i] - 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      ent_valid <= '0;
      for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
        ent_age[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
        ent_age[i] <= age_next[i];
      end
      if (issue_valid) begin
        ent_valid[sel_idx] <= 1'b0;  // Freed on the issue edge
      end
      if (dispatch_fire) begin
        ent_valid[free_idx] <= 1'b1;
        ent_age[free_idx]   <= '0;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    for (int i = 0; i < `OOO_RS_DEPTH; i++) begin
      if (cdb.valid && ent_valid[i] && !ent_a[i].ready && (ent_a[i].tag == cdb.tag)) begin
        ent_a[i].ready <= 1'b1;
        ent_a[i].value <= cdb.value;
      end
      if (cdb.valid && ent_valid[i] && !ent_b[i].ready && (ent_b[i].tag == cdb.tag)) begin
        ent_b[i].ready <= 1'b1;
        ent_b[i].value <= cdb.value;
      end
    end
    if (dispatch_fire) begin
      ent_op[free_idx]  <= op;
      ent_a[free_idx]   <= src1;
      ent_b[free_idx]   <= src2;
      ent_tag[free_idx] <= alloc_tag;
    end
  end

  // A ready operand always carries a known value
  a_issue_operands_ready: assert property (
    @(posedge in_clk) disable iff (!in_rst_n)
    issue_valid |-> !$isunknown({issue.a, issue.b})
  );

endmodule

/* rtl/reorder_buffer.sv */
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module reorder_buffer (
  input  logic                      in_clk,
  input  logic                      in_rst_n,
  input  logic                      dispatch_fire,
  input  ooo_pkg::dispatch_t        dispatch,
  input  ooo_pkg::operand_t         src1_raw,
  input  ooo_pkg::operand_t         src2_raw,
  output ooo_pkg::operand_t         src1,
  output ooo_pkg::operand_t         src2,
  output logic [`OOO_ROB_IDX_W-1:0] alloc_tag,
  output logic                      rob_free,
  input  ooo_pkg::cdb_t             cdb,
  output logic                      commit_valid,
  output ooo_pkg::commit_t          commit,
  input  logic                      commit_ready
);
  import ooo_pkg::*;

  localparam logic [`OOO_ROB_IDX_W:0] full_count = (`OOO_ROB_IDX_W + 1)'(`OOO_ROB_DEPTH);

  logic [`OOO_ROB_DEPTH-1:0] ent_valid;
  logic [`OOO_ROB_DEPTH-1:0] ent_done;  // Result captured from the bus
  logic [`OOO_REG_IDX_W-1:0] ent_dst [`OOO_ROB_DEPTH];
  logic [`OOO_XLEN-1:0]      ent_value [`OOO_ROB_DEPTH];

  logic [`OOO_ROB_IDX_W-1:0] head;
  logic [`OOO_ROB_IDX_W-1:0] tail;
  logic [`OOO_ROB_IDX_W:0]   count;
  logic                      head_hit;
  logic                      pop;

  // Fill in a pending operand from a finished entry or from this cycle's broadcast
  function automatic operand_t resolve(operand_t raw);
    operand_t res;
    res = raw;
    if (!raw.ready) begin
      if (ent_done[raw.tag]) begin
        res.ready = 1'b1;
        res.value = ent_value[raw.tag];
      end else if (cdb.valid && (cdb.tag == raw.tag)) begin
        res.ready = 1'b1;
        res.value = cdb.value;
      end
    end
    return res;
  endfunction

  always_comb begin
    src1 = resolve(src1_raw);
    if (dispatch.use_imm) begin
      src2 = '{ready: 1'b1, tag: '0, value: dispatch.imm};
    end else begin
      src2 = resolve(src2_raw);
    end
  end

  assign alloc_tag = tail;
  assign rob_free  = (count != full_count);

  // Head can retire in the same cycle its result is on the bus
  assign head_hit     = cdb.valid && (cdb.tag == head);
  assign commit_valid = ent_valid[head] && (ent_done[head] || head_hit);
  assign commit.dst   = ent_dst[head];
  assign commit.tag   = head;
  assign commit.value = ent_done[head] ? ent_value[head] : cdb.value;

  assign pop = commit_valid && commit_ready;

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      ent_valid <= '0;
      ent_done  <= '0;
      head      <= '0;
      tail      <= '0;
      count     <= '0;
    end else begin
      if (cdb.valid) begin
        ent_done[cdb.tag] <= 1'b1;
      end
      if (dispatch_fire) begin
        ent_valid[tail] <= 1'b1;
        ent_done[tail]  <= 1'b0;
        tail            <= tail + 1'b1;  // Wraps at depth
      end
      if (pop) begin
        ent_valid[head] <= 1'b0;
        head            <= head + 1'b1;
      end
      case ({dispatch_fire, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge in_clk) begin
    if (dispatch_fire) begin
      ent_dst[tail] <= dispatch.dst;
    end
    if (cdb.valid) begin
      ent_value[cdb.tag] <= cdb.value;
    end
  end

  // The top must hold off dispatch while the window is full
  a_no_alloc_when_full: assert property (
    @(posedge in_clk) disable iff (!in_rst_n)
    dispatch_fire |-> (count != full_count)
  );

  // Each tag is broadcast exactly once, while its entry is live
  a_cdb_names_live_entry: assert property (
    @(posedge in_clk) disable iff (!in_rst_n)
    cdb.valid |-> (ent_valid[cdb.tag] && !ent_done[cdb.tag])
  );

endmodule

/* rtl/rename_regfile.sv */
`timescale 1ns/1ns
`include "ooo_cfg.svh"

module rename_regfile (
  input  logic                      in_clk,
  input  logic                      in_rst_n,
  input  ooo_pkg::dispatch_t        dispatch,
  input  logic                      dispatch_fire,
  input  logic [`OOO_ROB_IDX_W-1:0] alloc_tag,
  output ooo_pkg::operand_t         src1_raw,
  output ooo_pkg::operand_t         src2_raw,
  input  logic                      commit_fire,
  input  ooo_pkg::commit_t          commit
);
  import ooo_pkg::*;

  logic [`OOO_XLEN-1:0]      reg_value [`OOO_NUM_REGS];
  logic [`OOO_NUM_REGS-1:0]  reg_busy;
  logic [`OOO_ROB_IDX_W-1:0] reg_tag [`OOO_NUM_REGS];
  logic                      rename_dst;
  logic                      commit_wr;
  logic                      commit_clear;

  // Committed value, or tag of the youngest in-flight producer
  function automatic operand_t lookup(logic [`OOO_REG_IDX_W-1:0] idx);
    operand_t res;
    res.ready = 1'b1;
    res.tag   = '0;
    res.value = '0;
    if (idx != '0) begin  // r0 is hardwired to zero
      if (reg_busy[idx]) begin
        res.ready = 1'b0;
        res.tag   = reg_tag[idx];
      end else begin
        res.value = reg_value[idx];
      end
    end
    return res;
  endfunction

  always_comb begin
    src1_raw = lookup(dispatch.src1);
    src2_raw = lookup(dispatch.src2);
  end

  assign rename_dst = dispatch_fire && (dispatch.dst != '0);
  assign commit_wr  = commit_fire && (commit.dst != '0);

  // Only the latest rename may release the register
  assign commit_clear = commit_wr && reg_busy[commit.dst] &&
                        (reg_tag[commit.dst] == commit.tag);

  always_ff @(posedge in_clk or negedge in_rst_n) begin
    if (!in_rst_n) begin
      reg_busy <= '0;
      for (int i = 0; i < `OOO_NUM_REGS; i++) begin
        reg_value[i] <= '0;
      end
    end else begin
      if (commit_wr) begin
        reg_value[commit.dst] <= commit.value;
      end
      if (commit_clear) begin
        reg_busy[commit.dst] <= 1'b0;
      end
      // Comes last so a same-edge rename keeps busy set
      if (rename_dst) begin
        reg_busy[dispatch.dst] <= 1'b1;
      end
    end
  end

  always_ff @(posedge in_clk) begin
    if (rename_dst) begin
      reg_tag[dispatch.dst] <= alloc_tag;
    end
  end

endmodule

/* rtl/ooo_pkg.sv */
`include "ooo_cfg.svh"

package ooo_pkg;

  typedef enum logic [2:0] {
    ALU_ADD = 3'd0,
    ALU_SUB = 3'd1,
    ALU_AND = 3'd2,
    ALU_OR  = 3'd3,
    ALU_XOR = 3'd4,
    ALU_SHL = 3'd5  // Shift by b[4:0]
  } alu_op_e;

  // Decoded instruction on the dispatch port
  typedef struct packed {
    alu_op_e                   op;
    logic [`OOO_REG_IDX_W-1:0] dst;
    logic [`OOO_REG_IDX_W-1:0] src1;
    logic [`OOO_REG_IDX_W-1:0] src2;
    logic                      use_imm;  // imm replaces src2
    logic [`OOO_XLEN-1:0]      imm;
  } dispatch_t;

  // Value when ready, producer tag otherwise
  typedef struct packed {
    logic                      ready;
    logic [`OOO_ROB_IDX_W-1:0] tag;
    logic [`OOO_XLEN-1:0]      value;
  } operand_t;

  typedef struct packed {
    alu_op_e                   op;
    logic [`OOO_XLEN-1:0]      a;
    logic [`OOO_XLEN-1:0]      b;
    logic [`OOO_ROB_IDX_W-1:0] tag;  // Destination ROB entry
  } issue_t;

  // Common data bus, one result per cycle
  typedef struct packed {
    logic                      valid;
    logic [`OOO_ROB_IDX_W-1:0] tag;
    logic [`OOO_XLEN-1:0]      value;
  } cdb_t;

  typedef struct packed {
    logic [`OOO_REG_IDX_W-1:0] dst;
    logic [`OOO_ROB_IDX_W-1:0] tag;
    logic [`OOO_XLEN-1:0]      value;
  } commit_t;

endpackage

/* rtl/ooo_cfg.svh */
`ifndef OOO_CFG_SVH
`define OOO_CFG_SVH

// Datapath and register file
`define OOO_XLEN 32
`define OOO_NUM_REGS 16
`define OOO_REG_IDX_W 4

// Window sizes
`define OOO_ROB_DEPTH 8
`define OOO_ROB_IDX_W 3
`define OOO_RS_DEPTH 4

`endif
